//--- verilog/fetch_cfg.svh
/*
 * fetch front end configuration
 * memory geometry and boot address of the instruction fetch path
 */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// depth of the instruction memory in 32-bit words
`define IMEM_WORDS 256

// byte address width, covers IMEM_WORDS * 4 bytes
`define IMEM_ADDR_W 10

// first fetch byte address
// must be word aligned, the aligner starts on a low halfword
`define FETCH_BOOT_ADDR 10'h000

`endif

//--- verilog/rv_isa_pkg.sv
/*
 * RV32 ISA definitions
 * instruction widths and the major opcodes targeted by RVC expansion
 */
package rv_isa_pkg;

  // full instruction and one 16-bit parcel
  typedef logic [31:0] instr_word_t;
  typedef logic [15:0] instr_half_t;

  // major opcode field, bits 6:0
  typedef logic [6:0]  opcode_t;

  ////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////

  // register-immediate alu
  localparam opcode_t OPCODE_OPIMM  = 7'b0010011;
  // register-register alu
  localparam opcode_t OPCODE_OP     = 7'b0110011;
  // memory access
  localparam opcode_t OPCODE_LOAD   = 7'b0000011;
  localparam opcode_t OPCODE_STORE  = 7'b0100011;
  // upper immediate
  localparam opcode_t OPCODE_LUI    = 7'b0110111;
  // control transfer
  localparam opcode_t OPCODE_JAL    = 7'b1101111;
  localparam opcode_t OPCODE_JALR   = 7'b1100111;
  localparam opcode_t OPCODE_BRANCH = 7'b1100011;

endpackage

//--- verilog/fetch_bus_pkg.sv
/*
 * instruction memory bus types
 * addresses, data words, bus ownership and aligner states
 */
`include "fetch_cfg.svh"

package fetch_bus_pkg;

  // byte address into the instruction memory
  typedef logic [`IMEM_ADDR_W-1:0] imem_addr_t;

  // one memory data word
  typedef logic [31:0] imem_word_t;

  // owner of the read in flight, tracked by the arbiter
  typedef enum logic [1:0] {
    OWNER_NONE,
    OWNER_LOADER,
    OWNER_FETCH
  } bus_owner_e;

  // aligner fsm: idle, request pending, read in flight
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT,
    FETCH_RUN
  } fetch_state_e;

endpackage

//--- verilog/imem_bus_if.sv
/*
 * instruction memory port
 * req/gnt level arbitration, read data returns one cycle after the transfer
 */
interface imem_bus_if;

  // requester side
  logic                      req;
  logic                      we;
  fetch_bus_pkg::imem_addr_t addr;
  fetch_bus_pkg::imem_word_t wdata;

  // memory side
  logic                      gnt;
  fetch_bus_pkg::imem_word_t rdata;
  // single cycle pulse, reads only
  logic                      rvalid;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata, rvalid
  );

  modport memory (
    input  req, we, addr, wdata,
    output gnt, rdata, rvalid
  );

endinterface

//--- verilog/imem_arbiter.sv
/*
 * fixed-priority arbiter for the shared instruction memory
 * loader beats fetch, read responses return to the peer that issued them
 */
module imem_arbiter (
  input  logic       clk_i,
  input  logic       rst_n_i,
  imem_bus_if.memory    load_bus,
  imem_bus_if.memory    fetch_bus,
  imem_bus_if.requester mem_bus
);

  import fetch_bus_pkg::*;

  logic       load_wins;
  bus_owner_e owner_d;
  bus_owner_e owner_q;

  // loader has absolute priority
  assign load_wins = load_bus.req;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  assign mem_bus.req   = load_bus.req | fetch_bus.req;
  assign mem_bus.we    = load_wins ? load_bus.we    : fetch_bus.we;
  assign mem_bus.addr  = load_wins ? load_bus.addr  : fetch_bus.addr;
  assign mem_bus.wdata = load_wins ? load_bus.wdata : fetch_bus.wdata;

  // grants are combinational, fetch only gets the leftover cycles
  assign load_bus.gnt  = load_bus.req & mem_bus.gnt;
  assign fetch_bus.gnt = fetch_bus.req & ~load_bus.req & mem_bus.gnt;

  ////////////////////////////////////////////////////////////
  // response routing
  ////////////////////////////////////////////////////////////

  // remember who issued the read granted this cycle
  always_comb begin
    owner_d = OWNER_NONE;
    if (mem_bus.req && mem_bus.gnt && !mem_bus.we) begin
      owner_d = load_wins ? OWNER_LOADER : OWNER_FETCH;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      owner_q <= OWNER_NONE;
    end else begin
      owner_q <= owner_d;
    end
  end

  // the other peer sees neither the strobe nor the data
  assign load_bus.rvalid  = mem_bus.rvalid & (owner_q == OWNER_LOADER);
  assign load_bus.rdata   = (owner_q == OWNER_LOADER) ? mem_bus.rdata : '0;
  assign fetch_bus.rvalid = mem_bus.rvalid & (owner_q == OWNER_FETCH);
  assign fetch_bus.rdata  = (owner_q == OWNER_FETCH) ? mem_bus.rdata : '0;

endmodule

//--- verilog/instr_mem.sv
/*
 * single-port instruction RAM
 * word organised, always granted, one cycle read latency
 */
`include "fetch_cfg.svh"

module instr_mem (
  input  logic       clk_i,
  imem_bus_if.memory mem_bus
);

  import fetch_bus_pkg::*;

  localparam int WORD_IDX_W = $clog2(`IMEM_WORDS);

  imem_word_t            mem_q [`IMEM_WORDS];
  imem_word_t            rdata_q;
  logic                  rvalid_q;
  logic [WORD_IDX_W-1:0] word_idx;

  // byte address to word index, drop bits 1:0
  assign word_idx = mem_bus.addr[WORD_IDX_W+1:2];

  // no contention on this side of the arbiter
  assign mem_bus.gnt = 1'b1;

  always_ff @(posedge clk_i) begin
    if (mem_bus.req && mem_bus.gnt && mem_bus.we) begin
      mem_q[word_idx] <= mem_bus.wdata;
    end
    rdata_q  <= mem_q[word_idx];
    // response strobe only for reads
    rvalid_q <= mem_bus.req & mem_bus.gnt & ~mem_bus.we;
  end

  assign mem_bus.rdata  = rdata_q;
  assign mem_bus.rvalid = rvalid_q;

endmodule

//--- verilog/fetch_aligner.sv
/*
 * sequential word fetcher and halfword realigner
 * emits one raw instruction per valid pulse, 16 or 32 bits, any alignment
 */
`include "fetch_cfg.svh"

module fetch_aligner (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      fetch_en_i,
  imem_bus_if.requester             bus,
  input  logic                      is_compressed_i,
  output logic                      instr_valid_o,
  output rv_isa_pkg::instr_word_t   raw_instr_o,
  output fetch_bus_pkg::imem_addr_t pc_o
);

  import rv_isa_pkg::*;
  import fetch_bus_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  imem_addr_t   fetch_addr_q;
  imem_addr_t   pc_q;
  instr_half_t  half_q;
  logic         half_vld_q;
  logic         valid_q;
  instr_word_t  window_q;
  logic         half_is_c;
  logic         take_word;
  logic         take_half;

  // leftover parcel is a whole compressed instruction
  assign half_is_c = half_vld_q && (half_q[1:0] != 2'b11);

  // a word arrives, or the leftover goes out without a read
  assign take_word = (state_q == FETCH_RUN) && bus.rvalid;
  assign take_half = (state_q == FETCH_IDLE) && fetch_en_i && half_is_c;

  ////////////////////////////////////////////////////////////
  // read fsm, one read in flight at most
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (fetch_en_i && !half_is_c) begin
          state_d = FETCH_WAIT;
        end
      end
      // hold req until granted
      FETCH_WAIT: begin
        if (bus.gnt) begin
          state_d = FETCH_RUN;
        end
      end
      FETCH_RUN: begin
        if (bus.rvalid) begin
          state_d = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= FETCH_IDLE;
      fetch_addr_q <= `FETCH_BOOT_ADDR;
      pc_q         <= `FETCH_BOOT_ADDR;
      half_vld_q   <= 1'b0;
      valid_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= take_word | take_half;
      if (bus.req && bus.gnt) begin
        fetch_addr_q <= fetch_addr_q + imem_addr_t'(4);
      end
      // decoder tells how much of the window was consumed
      if (valid_q) begin
        pc_q <= pc_q + (is_compressed_i ? imem_addr_t'(2) : imem_addr_t'(4));
      end
      // upper half stays buffered unless it completed a 32-bit instruction
      if (take_word) begin
        half_vld_q <= half_vld_q | (bus.rdata[1:0] != 2'b11);
      end else if (take_half) begin
        half_vld_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // instruction window
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (take_word) begin
      // straddling instruction: low parcel from the old word
      window_q <= half_vld_q ? {bus.rdata[15:0], half_q} : bus.rdata;
      half_q   <= bus.rdata[31:16];
    end else if (take_half) begin
      window_q <= {16'h0000, half_q};
    end
  end

  // fetch only reads
  assign bus.req   = (state_q == FETCH_WAIT);
  assign bus.we    = 1'b0;
  assign bus.addr  = fetch_addr_q;
  assign bus.wdata = '0;

  assign instr_valid_o = valid_q;
  assign raw_instr_o   = window_q;
  assign pc_o          = pc_q;

endmodule

//--- verilog/compressed_decoder.sv
/*
 * RVC decoder, expands 16-bit instructions into their RV32I form
 * flags reserved and floating-point encodings, 32-bit words pass through
 */
module compressed_decoder (
  input  rv_isa_pkg::instr_word_t instr_i,
  output rv_isa_pkg::instr_word_t instr_o,
  output logic                    is_compressed_o,
  output logic                    illegal_instr_o
);

  import rv_isa_pkg::*;

  always_comb begin
    instr_o         = instr_i;
    illegal_instr_o = 1'b0;

    case (instr_i[1:0])
      ////////////////////////////////////////////////////////////
      // quadrant 0
      ////////////////////////////////////////////////////////////
      2'b00: begin
        case (instr_i[15:13])
          3'b000: begin
            // c.addi4spn -> addi rd', x2, nzuimm
            instr_o = {2'b00, instr_i[10:7], instr_i[12:11], instr_i[5], instr_i[6], 2'b00,
                       5'd2, 3'b000, 2'b01, instr_i[4:2], OPCODE_OPIMM};
            // zero immediate reserved, this also catches the all-zero parcel
            illegal_instr_o = (instr_i[12:5] == 8'h00);
          end
          3'b010: begin
            // c.lw -> lw rd', uimm(rs1')
            instr_o = {5'b00000, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                       2'b01, instr_i[9:7], 3'b010, 2'b01, instr_i[4:2], OPCODE_LOAD};
          end
          3'b110: begin
            // c.sw -> sw rs2', uimm(rs1')
            instr_o = {5'b00000, instr_i[5], instr_i[12], 2'b01, instr_i[4:2], 2'b01,
                       instr_i[9:7], 3'b010, instr_i[11:10], instr_i[6], 2'b00, OPCODE_STORE};
          end
          // c.fld, c.flw, c.fsd, c.fsw, reserved slot 100
          default: illegal_instr_o = 1'b1;
        endcase
      end

      ////////////////////////////////////////////////////////////
      // quadrant 1
      ////////////////////////////////////////////////////////////
      2'b01: begin
        case (instr_i[15:13])
          3'b000: begin
            // c.addi / c.nop -> addi rd, rd, imm
            instr_o = {{7{instr_i[12]}}, instr_i[6:2], instr_i[11:7], 3'b000, instr_i[11:7],
                       OPCODE_OPIMM};
          end
          3'b001, 3'b101: begin
            // c.jal -> jal x1 / c.j -> jal x0, bit 15 picks the link register
            instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                       instr_i[2], instr_i[11], instr_i[5:3], {9{instr_i[12]}}, 4'b0000,
                       ~instr_i[15], OPCODE_JAL};
          end
          3'b010: begin
            // c.li -> addi rd, x0, imm (rd = x0 is a hint)
            instr_o = {{7{instr_i[12]}}, instr_i[6:2], 5'd0, 3'b000, instr_i[11:7], OPCODE_OPIMM};
          end
          3'b011: begin
            if ({instr_i[12], instr_i[6:2]} == 6'b000000) begin
              // zero immediate reserved for both c.addi16sp and c.lui
              illegal_instr_o = 1'b1;
            end else if (instr_i[11:7] == 5'd2) begin
              // c.addi16sp -> addi x2, x2, nzimm
              instr_o = {{3{instr_i[12]}}, instr_i[4:3], instr_i[5], instr_i[2], instr_i[6],
                         4'b0000, 5'd2, 3'b000, 5'd2, OPCODE_OPIMM};
            end else begin
              // c.lui -> lui rd, nzimm
              instr_o = {{15{instr_i[12]}}, instr_i[6:2], instr_i[11:7], OPCODE_LUI};
            end
          end
          3'b100: begin
            case (instr_i[11:10])
              2'b00, 2'b01: begin
                // c.srli / c.srai, shamt[5] must be clear on RV32
                instr_o = {1'b0, instr_i[10], 5'b00000, instr_i[6:2], 2'b01, instr_i[9:7],
                           3'b101, 2'b01, instr_i[9:7], OPCODE_OPIMM};
                illegal_instr_o = instr_i[12];
              end
              2'b10: begin
                // c.andi -> andi rd', rd', imm
                instr_o = {{7{instr_i[12]}}, instr_i[6:2], 2'b01, instr_i[9:7], 3'b111,
                           2'b01, instr_i[9:7], OPCODE_OPIMM};
              end
              default: begin
                // register ops, funct3 by bits 6:5
                case (instr_i[6:5])
                  2'b00: instr_o = {7'b0100000, 2'b01, instr_i[4:2], 2'b01, instr_i[9:7],
                                    3'b000, 2'b01, instr_i[9:7], OPCODE_OP};
                  2'b01: instr_o = {7'b0000000, 2'b01, instr_i[4:2], 2'b01, instr_i[9:7],
                                    3'b100, 2'b01, instr_i[9:7], OPCODE_OP};
                  2'b10: instr_o = {7'b0000000, 2'b01, instr_i[4:2], 2'b01, instr_i[9:7],
                                    3'b110, 2'b01, instr_i[9:7], OPCODE_OP};
                  default: instr_o = {7'b0000000, 2'b01, instr_i[4:2], 2'b01, instr_i[9:7],
                                      3'b111, 2'b01, instr_i[9:7], OPCODE_OP};
                endcase
                // c.subw and c.addw are RV64 only
                illegal_instr_o = instr_i[12];
              end
            endcase
          end
          default: begin
            // c.beqz / c.bnez -> beq / bne rs1', x0, imm
            instr_o = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2], 5'd0, 2'b01, instr_i[9:7],
                       2'b00, instr_i[13], instr_i[11:10], instr_i[4:3], instr_i[12],
                       OPCODE_BRANCH};
          end
        endcase
      end

      ////////////////////////////////////////////////////////////
      // quadrant 2
      ////////////////////////////////////////////////////////////
      2'b10: begin
        case (instr_i[15:13])
          3'b000: begin
            // c.slli -> slli rd, rd, shamt
            instr_o = {7'b0000000, instr_i[6:2], instr_i[11:7], 3'b001, instr_i[11:7],
                       OPCODE_OPIMM};
            illegal_instr_o = instr_i[12];
          end
          3'b010: begin
            // c.lwsp -> lw rd, uimm(x2), rd = x0 reserved
            instr_o = {4'b0000, instr_i[3:2], instr_i[12], instr_i[6:4], 2'b00, 5'd2, 3'b010,
                       instr_i[11:7], OPCODE_LOAD};
            illegal_instr_o = (instr_i[11:7] == 5'd0);
          end
          3'b100: begin
            if (instr_i[6:2] != 5'd0) begin
              // c.mv -> add rd, x0, rs2 / c.add -> add rd, rd, rs2
              instr_o = {7'b0000000, instr_i[6:2], instr_i[12] ? instr_i[11:7] : 5'd0,
                         3'b000, instr_i[11:7], OPCODE_OP};
            end else if (!instr_i[12]) begin
              // c.jr -> jalr x0, 0(rs1), rs1 = x0 reserved
              instr_o = {12'h000, instr_i[11:7], 3'b000, 5'd0, OPCODE_JALR};
              illegal_instr_o = (instr_i[11:7] == 5'd0);
            end else if (instr_i[11:7] == 5'd0) begin
              // c.ebreak
              instr_o = 32'h00100073;
            end else begin
              // c.jalr -> jalr x1, 0(rs1)
              instr_o = {12'h000, instr_i[11:7], 3'b000, 5'd1, OPCODE_JALR};
            end
          end
          3'b110: begin
            // c.swsp -> sw rs2, uimm(x2)
            instr_o = {4'b0000, instr_i[8:7], instr_i[12], instr_i[6:2], 5'd2, 3'b010,
                       instr_i[11:9], 2'b00, OPCODE_STORE};
          end
          // c.fldsp, c.flwsp, c.fsdsp, c.fswsp
          default: illegal_instr_o = 1'b1;
        endcase
      end

      // 32-bit instruction, already copied
      default: ;
    endcase
  end

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

endmodule

//--- verilog/fetch_top.sv
/*
 * instruction fetch front end
 * loader port and fetch aligner share one RAM, the decoder expands RVC
 */
module fetch_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      fetch_en_i,
  input  logic                      load_we_i,
  input  fetch_bus_pkg::imem_addr_t load_addr_i,
  input  fetch_bus_pkg::imem_word_t load_wdata_i,
  output logic                      instr_valid_o,
  output rv_isa_pkg::instr_word_t   instr_o,
  output fetch_bus_pkg::imem_addr_t pc_o,
  output logic                      is_compressed_o,
  output logic                      illegal_instr_o
);

  import rv_isa_pkg::*;

  // aligner window into the decoder
  instr_word_t raw_instr;

  imem_bus_if load_bus ();
  imem_bus_if fetch_bus ();
  imem_bus_if mem_bus ();

  // loader only writes, a write strobe is its request
  assign load_bus.req   = load_we_i;
  assign load_bus.we    = load_we_i;
  assign load_bus.addr  = load_addr_i;
  assign load_bus.wdata = load_wdata_i;

  imem_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .load_bus  (load_bus.memory),
    .fetch_bus (fetch_bus.memory),
    .mem_bus   (mem_bus.requester)
  );

  instr_mem u_mem (
    .clk_i   (clk_i),
    .mem_bus (mem_bus.memory)
  );

  fetch_aligner u_aligner (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_en_i      (fetch_en_i),
    .bus             (fetch_bus.requester),
    .is_compressed_i (is_compressed_o),
    .instr_valid_o   (instr_valid_o),
    .raw_instr_o     (raw_instr),
    .pc_o            (pc_o)
  );

  compressed_decoder u_decoder (
    .instr_i         (raw_instr),
    .instr_o         (instr_o),
    .is_compressed_o (is_compressed_o),
    .illegal_instr_o (illegal_instr_o)
  );

endmodule

//--- verification/fetch_checker.sv
/*
 * fetch bus checker
 * grant exclusivity and read response timing on the arbiter
 */
module fetch_checker (
  input logic clk_i,
  input logic rst_n_i,
  input logic load_gnt_i,
  input logic fetch_gnt_i,
  input logic mem_req_i,
  input logic mem_gnt_i,
  input logic mem_we_i,
  input logic mem_rvalid_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // a read transfer on the memory side
  logic mem_read;

  assign mem_read = mem_req_i & mem_gnt_i & ~mem_we_i;

  // only one peer may own the memory in a cycle
  a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(load_gnt_i && fetch_gnt_i))
    else $error("loader and fetch granted in the same cycle");

  // read data comes back exactly one cycle after the transfer
  a_read_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_read |=> mem_rvalid_i)
    else $error("granted read got no rvalid one cycle later");

  a_no_stray_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rvalid_i |-> $past(mem_read))
    else $error("rvalid without a read in the previous cycle");

endmodule

bind imem_arbiter fetch_checker u_checker (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .load_gnt_i    (load_bus.gnt),
  .fetch_gnt_i   (fetch_bus.gnt),
  .mem_req_i     (mem_bus.req),
  .mem_gnt_i     (mem_bus.gnt),
  .mem_we_i      (mem_bus.we),
  .mem_rvalid_i  (mem_bus.rvalid)
);

//--- verification/fetch_tb.sv
/*
 * fetch front end testbench
 * loads a mixed RVC/RV32I program, checks every fetched instruction in order
 */
module fetch_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import rv_isa_pkg::*;
  import fetch_bus_pkg::*;

  localparam int VALID_TIMEOUT    = 200;
  localparam int CONTENTION_LIMIT = 5000;
  localparam int IDLE_CYCLES      = 5;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        fetch_en_i;
  logic        load_we_i;
  imem_addr_t  load_addr_i;
  imem_word_t  load_wdata_i;
  logic        instr_valid_o;
  instr_word_t instr_o;
  imem_addr_t  pc_o;
  logic        is_compressed_o;
  logic        illegal_instr_o;

  // program parcels, packed words and the expected columns
  instr_half_t parcel_q[$];
  imem_word_t  prog_q[$];
  instr_word_t exp_instr_q[$];
  imem_addr_t  exp_pc_q[$];
  logic        exp_c_q[$];
  logic        exp_ill_q[$];

  logic [31:0] lfsr_q      = 32'h4943e0ab;
  logic        stream_done = 1'b0;
  int          value_errs  = 0;
  int          early_errs  = 0;
  int          timeout_errs = 0;
  int          checked     = 0;

  always #50 clk_i = ~clk_i;

  fetch_top dut_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_en_i      (fetch_en_i),
    .load_we_i       (load_we_i),
    .load_addr_i     (load_addr_i),
    .load_wdata_i    (load_wdata_i),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .pc_o            (pc_o),
    .is_compressed_o (is_compressed_o),
    .illegal_instr_o (illegal_instr_o)
  );

  //////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////

  // one row per instruction, 32-bit rows take two parcels
  task automatic add_entry(input instr_word_t raw, input instr_word_t exp,
                           input imem_addr_t pc, input logic is_c, input logic ill);
    parcel_q.push_back(raw[15:0]);
    if (!is_c) begin
      parcel_q.push_back(raw[31:16]);
    end
    exp_instr_q.push_back(exp);
    exp_pc_q.push_back(pc);
    exp_c_q.push_back(is_c);
    exp_ill_q.push_back(ill);
  endtask

  task automatic build_table();
    //        raw           expanded      pc      c     illegal
    add_entry(32'h00500093, 32'h00500093, 10'd0,  1'b0, 1'b0);
    add_entry(32'h0000050D, 32'h00350513, 10'd4,  1'b1, 1'b0);
    // lui x5 straddles words 1 and 2
    add_entry(32'h123452B7, 32'h123452B7, 10'd6,  1'b0, 1'b0);
    add_entry(32'h000055FD, 32'hFFF00593, 10'd10, 1'b1, 1'b0);
    add_entry(32'h00006605, 32'h00001637, 10'd12, 1'b1, 1'b0);
    add_entry(32'h00006105, 32'h02010113, 10'd14, 1'b1, 1'b0);
    add_entry(32'h0000800D, 32'h00345413, 10'd16, 1'b1, 1'b0);
    add_entry(32'h000098F9, 32'hFFE4F493, 10'd18, 1'b1, 1'b0);
    add_entry(32'h00008C05, 32'h40940433, 10'd20, 1'b1, 1'b0);
    // c.j, c.jal, c.beqz, pc still moves forward
    add_entry(32'h0000A021, 32'h0080006F, 10'd22, 1'b1, 1'b0);
    add_entry(32'h00003FF5, 32'hFFDFF0EF, 10'd24, 1'b1, 1'b0);
    add_entry(32'h0000C119, 32'h00050363, 10'd26, 1'b1, 1'b0);
    add_entry(32'h00004044, 32'h00442483, 10'd28, 1'b1, 1'b0);
    add_entry(32'h0000C404, 32'h00942423, 10'd30, 1'b1, 1'b0);
    add_entry(32'h002081B3, 32'h002081B3, 10'd32, 1'b0, 1'b0);
    add_entry(32'h000040B2, 32'h00C12083, 10'd36, 1'b1, 1'b0);
    add_entry(32'h0000C806, 32'h00112823, 10'd38, 1'b1, 1'b0);
    add_entry(32'h0000829A, 32'h006002B3, 10'd40, 1'b1, 1'b0);
    add_entry(32'h0F02E393, 32'h0F02E393, 10'd42, 1'b0, 1'b0);
    add_entry(32'h0000929A, 32'h006282B3, 10'd46, 1'b1, 1'b0);
    add_entry(32'h00008082, 32'h00008067, 10'd48, 1'b1, 1'b0);
    add_entry(32'h00009282, 32'h000280E7, 10'd50, 1'b1, 1'b0);
    add_entry(32'h00009002, 32'h00100073, 10'd52, 1'b1, 1'b0);
    // zero parcel, c.flw, c.addi16sp 0, c.jr x0, c.lwsp x0
    add_entry(32'h00000000, 32'h00000000, 10'd54, 1'b1, 1'b1);
    add_entry(32'h00006000, 32'h00000000, 10'd56, 1'b1, 1'b1);
    add_entry(32'h00006101, 32'h00000000, 10'd58, 1'b1, 1'b1);
    add_entry(32'h00008002, 32'h00000000, 10'd60, 1'b1, 1'b1);
    add_entry(32'h00004012, 32'h00000000, 10'd62, 1'b1, 1'b1);
    add_entry(32'hFFF20213, 32'hFFF20213, 10'd64, 1'b0, 1'b0);
  endtask

  // parcels into little-endian words, plus a few addi nops past the end
  task automatic pack_program();
    if (parcel_q.size() % 2 != 0) begin
      parcel_q.push_back(16'h0001);
    end
    for (int k = 0; k < parcel_q.size() / 2; k++) begin
      prog_q.push_back({parcel_q[2*k+1], parcel_q[2*k]});
    end
    for (int k = 0; k < 3; k++) begin
      prog_q.push_back(32'h00000013);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////

  // galois lfsr, one step per bit drawn
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw_bit(output logic b);
    b      = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_idle();
    assert (instr_valid_o === 1'b0) else begin
      early_errs++;
      $display("instruction valid pulse at %0t ns while fetch was disabled", $time);
    end
  endtask

  task automatic load_program();
    for (int w = 0; w < prog_q.size(); w++) begin
      @(posedge clk_i);
      load_we_i    <= 1'b1;
      load_addr_i  <= imem_addr_t'(w * 4);
      load_wdata_i <= prog_q[w];
      @(negedge clk_i);
      expect_idle();
    end
    @(posedge clk_i);
    load_we_i <= 1'b0;
  endtask

  // sample at negedge, outputs settle after the rising edge
  task automatic wait_valid(output logic seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < VALID_TIMEOUT) begin
      @(negedge clk_i);
      seen = instr_valid_o;
      cycles++;
    end
  endtask

  task automatic check_stream();
    logic seen;
    for (int i = 0; i < exp_instr_q.size(); i++) begin
      wait_valid(seen);
      if (!seen) begin
        timeout_errs++;
        $display("instruction %0d never came out within %0d cycles", i, VALID_TIMEOUT);
        break;
      end
      // expansion of an illegal parcel is undefined
      if (!exp_ill_q[i]) begin
        compare_value("instr_o", instr_o, exp_instr_q[i]);
      end
      compare_value("pc_o", 32'(pc_o), 32'(exp_pc_q[i]));
      compare_value("is_compressed_o", 32'(is_compressed_o), 32'(exp_c_q[i]));
      compare_value("illegal_instr_o", 32'(illegal_instr_o), 32'(exp_ill_q[i]));
      checked++;
    end
  endtask

  // loader writes into words 128..255, far above the program
  task automatic drive_contention();
    logic       hit;
    logic [6:0] slot;
    int         cycles;
    slot   = '0;
    cycles = 0;
    while (!stream_done && cycles < CONTENTION_LIMIT) begin
      @(posedge clk_i);
      draw_bit(hit);
      load_we_i    <= hit;
      load_addr_i  <= {1'b1, slot, 2'b00};
      load_wdata_i <= {25'd0, slot};
      if (hit) begin
        slot = slot + 7'd1;
      end
      cycles++;
    end
    @(posedge clk_i);
    load_we_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////

  initial begin
    rst_n_i      <= 1'b0;
    fetch_en_i   <= 1'b0;
    load_we_i    <= 1'b0;
    load_addr_i  <= '0;
    load_wdata_i <= '0;
    build_table();
    pack_program();
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    load_program();
    // nothing may come out before enable
    for (int c = 0; c < IDLE_CYCLES; c++) begin
      @(negedge clk_i);
      expect_idle();
    end
    @(posedge clk_i);
    fetch_en_i <= 1'b1;
    fork
      begin
        check_stream();
        stream_done = 1'b1;
      end
      drive_contention();
    join
    @(posedge clk_i);
    fetch_en_i <= 1'b0;
    $display("checked %0d of %0d, value errors %0d, early valid %0d, timeouts %0d",
             checked, exp_instr_q.size(), value_errs, early_errs, timeout_errs);
    if (value_errs == 0 && early_errs == 0 && timeout_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/fetch_bus_pkg.sv
verilog/imem_bus_if.sv
verilog/imem_arbiter.sv
verilog/instr_mem.sv
verilog/fetch_aligner.sv
verilog/compressed_decoder.sv
verilog/fetch_top.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps
TOP       ?= fetch_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
